// ==== filelist.f ====
hw/chip_pkg.sv
hw/dps_pad_mux.sv
hw/spi_mbox_dev.sv
hw/jtag_idcode_tap.sv
hw/mbox_ram.sv
hw/chip_dps_top.sv
verif/chip_dps_asserts.sv
verif/tb_chip_dps.sv

// ==== hw/chip_dps_top.sv ====
//**************************************************************************
// Debug-pad subsystem. jtag_spi_n strap high selects JTAG, low selects SPI;
// it is taken once after reset. TCK and SCK must stay below clk/8.
//**************************************************************************
`timescale 1ns/1ps

module chip_dps_top import chip_pkg::*; #(
  parameter int MBOX_CREDITS = 2
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  dps_sck_tck_i,
  input  logic  dps_sdi_tdi_i,
  input  logic  dps_csb_tms_i,
  input  logic  dps_trst_n_i,
  input  logic  dps_strap_jtag_spi_n_i,
  output logic  dps_sdo_tdo_o,
  output logic  status_valid_o,
  output word_t status_o,
  output logic  log_valid_o,
  output word_t log_o
);

  logic       spi_sck;
  logic       spi_sdi;
  logic       spi_csb;
  logic       spi_sdo;
  logic       jtag_tck;
  logic       jtag_tdi;
  logic       jtag_tms;
  logic       jtag_trst_n;
  logic       jtag_tdo;
  logic       wr_valid;
  mbox_addr_t wr_addr;
  word_t      wr_data;
  mbox_addr_t rd_addr;
  word_t      rd_data;
  logic       credit;

  dps_pad_mux u_pad_mux (
    .clk_i                  (clk_i),
    .arst_n_i               (arst_n_i),
    .dps_sck_tck_i          (dps_sck_tck_i),
    .dps_sdi_tdi_i          (dps_sdi_tdi_i),
    .dps_csb_tms_i          (dps_csb_tms_i),
    .dps_trst_n_i           (dps_trst_n_i),
    .dps_strap_jtag_spi_n_i (dps_strap_jtag_spi_n_i),
    .spi_sdo_i              (spi_sdo),
    .jtag_tdo_i             (jtag_tdo),
    .dps_sdo_tdo_o          (dps_sdo_tdo_o),
    .spi_sck_o              (spi_sck),
    .spi_sdi_o              (spi_sdi),
    .spi_csb_o              (spi_csb),
    .jtag_tck_o             (jtag_tck),
    .jtag_tdi_o             (jtag_tdi),
    .jtag_tms_o             (jtag_tms),
    .jtag_trst_n_o          (jtag_trst_n)
  );

  spi_mbox_dev #(
    .MBOX_CREDITS (MBOX_CREDITS)
  ) u_spi_dev (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .sck_i      (spi_sck),
    .sdi_i      (spi_sdi),
    .csb_i      (spi_csb),
    .credit_i   (credit),
    .rd_data_i  (rd_data),
    .sdo_o      (spi_sdo),
    .wr_valid_o (wr_valid),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .rd_addr_o  (rd_addr)
  );

  jtag_idcode_tap u_tap (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .tck_i    (jtag_tck),
    .tms_i    (jtag_tms),
    .tdi_i    (jtag_tdi),
    .trst_n_i (jtag_trst_n),
    .tdo_o    (jtag_tdo)
  );

  mbox_ram u_mbox (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wr_valid_i     (wr_valid),
    .wr_addr_i      (wr_addr),
    .wr_data_i      (wr_data),
    .rd_addr_i      (rd_addr),
    .rd_data_o      (rd_data),
    .credit_o       (credit),
    .status_valid_o (status_valid_o),
    .status_o       (status_o),
    .log_valid_o    (log_valid_o),
    .log_o          (log_o)
  );

endmodule

// ==== hw/chip_pkg.sv ====
//**************************************************************************
// Shared types and constants of the debug-pad subsystem.
// Mailbox addresses are word indices, not byte addresses.
//**************************************************************************
package chip_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  mbox_addr_t;

  // Bit 7 selects write, bits 3..0 address the mailbox, bits 6..4 are ignored
  typedef logic [7:0]  frame_cmd_t;

  // Snooped mailbox words
  localparam mbox_addr_t MBOX_STATUS_ADDR = 4'd14;
  localparam mbox_addr_t MBOX_LOG_ADDR    = 4'd15;

  // Bit 0 must be 1 per IEEE 1149.1
  localparam word_t JTAG_IDCODE = 32'h4F54_4E11;

  localparam logic [3:0] IR_IDCODE = 4'h1;
  localparam logic [3:0] IR_BYPASS = 4'hF;

  typedef enum logic [3:0] {
    TAP_RESET, TAP_IDLE,
    TAP_SEL_DR, TAP_CAP_DR, TAP_SH_DR, TAP_EX1_DR,
    TAP_PAU_DR, TAP_EX2_DR, TAP_UPD_DR,
    TAP_SEL_IR, TAP_CAP_IR, TAP_SH_IR, TAP_EX1_IR,
    TAP_PAU_IR, TAP_EX2_IR, TAP_UPD_IR
  } tap_state_e;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_CMD,
    SPI_DATA
  } spi_state_e;

endpackage

// ==== hw/dps_pad_mux.sv ====
//**************************************************************************
// The strap pad is sampled once, on the first clk edge after reset release.
// It is assumed static around that edge and is not synchronized.
//**************************************************************************
`timescale 1ns/1ps

module dps_pad_mux (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic dps_sck_tck_i,
  input  logic dps_sdi_tdi_i,
  input  logic dps_csb_tms_i,
  input  logic dps_trst_n_i,
  input  logic dps_strap_jtag_spi_n_i,
  input  logic spi_sdo_i,
  input  logic jtag_tdo_i,
  output logic dps_sdo_tdo_o,
  output logic spi_sck_o,
  output logic spi_sdi_o,
  output logic spi_csb_o,
  output logic jtag_tck_o,
  output logic jtag_tdi_o,
  output logic jtag_tms_o,
  output logic jtag_trst_n_o
);

  logic strap_taken_q;
  logic strap_q;
  logic jtag_sel;
  logic spi_sel;

  // Latch the strap once per reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_taken_q <= 1'b0;
      strap_q       <= 1'b0;
    end else if (!strap_taken_q) begin
      strap_taken_q <= 1'b1;
      strap_q       <= dps_strap_jtag_spi_n_i;
    end
  end

  // Neither port owns the pads until the strap is taken
  assign jtag_sel = strap_taken_q & strap_q;
  assign spi_sel  = strap_taken_q & ~strap_q;

  // SPI side, parked with csb high and sck low
  assign spi_sck_o = spi_sel ? dps_sck_tck_i : 1'b0;
  assign spi_sdi_o = spi_sel ? dps_sdi_tdi_i : 1'b0;
  assign spi_csb_o = spi_sel ? dps_csb_tms_i : 1'b1;

  // JTAG side, parked in reset with tck low
  assign jtag_tck_o    = jtag_sel ? dps_sck_tck_i : 1'b0;
  assign jtag_tdi_o    = jtag_sel ? dps_sdi_tdi_i : 1'b0;
  assign jtag_tms_o    = jtag_sel ? dps_csb_tms_i : 1'b1;
  assign jtag_trst_n_o = jtag_sel ? dps_trst_n_i  : 1'b0;

  // Shared output pad
  always_comb begin
    if (jtag_sel) begin
      dps_sdo_tdo_o = jtag_tdo_i;
    end else if (spi_sel) begin
      dps_sdo_tdo_o = spi_sdo_i;
    end else begin
      dps_sdo_tdo_o = 1'b0;
    end
  end

endmodule

// ==== hw/jtag_idcode_tap.sv ====
//**************************************************************************
// JTAG TAP with IDCODE and BYPASS only, oversampled by clk.
// TCK must stay below clk/8. Unknown instructions select BYPASS.
//**************************************************************************
`timescale 1ns/1ps

module jtag_idcode_tap import chip_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic tck_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic trst_n_i,
  output logic tdo_o
);

  logic [1:0] tck_sync_q;
  logic [1:0] tms_sync_q;
  logic [1:0] tdi_sync_q;
  logic [1:0] trst_sync_q;
  logic       tck_prev_q;
  logic       tck_rise;
  logic       tck_fall;
  logic       tms;
  logic       tdi;
  tap_state_e state_q;
  tap_state_e state_d;
  logic [3:0] ir_q;
  logic [3:0] ir_sr_q;
  word_t      dr_sr_q;
  logic       bypass_q;
  logic       idcode_sel;
  logic       tdo_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tck_sync_q  <= 2'b00;
      tms_sync_q  <= 2'b11;
      tdi_sync_q  <= 2'b00;
      trst_sync_q <= 2'b00;
      tck_prev_q  <= 1'b0;
    end else begin
      tck_sync_q  <= {tck_sync_q[0], tck_i};
      tms_sync_q  <= {tms_sync_q[0], tms_i};
      tdi_sync_q  <= {tdi_sync_q[0], tdi_i};
      trst_sync_q <= {trst_sync_q[0], trst_n_i};
      tck_prev_q  <= tck_sync_q[1];
    end
  end

  assign tms      = tms_sync_q[1];
  assign tdi      = tdi_sync_q[1];
  assign tck_rise = tck_sync_q[1] & ~tck_prev_q;
  assign tck_fall = ~tck_sync_q[1] & tck_prev_q;

  // IEEE 1149.1 state diagram
  always_comb begin
    unique case (state_q)
      TAP_RESET:  state_d = tms ? TAP_RESET  : TAP_IDLE;
      TAP_IDLE:   state_d = tms ? TAP_SEL_DR : TAP_IDLE;
      TAP_SEL_DR: state_d = tms ? TAP_SEL_IR : TAP_CAP_DR;
      TAP_CAP_DR: state_d = tms ? TAP_EX1_DR : TAP_SH_DR;
      TAP_SH_DR:  state_d = tms ? TAP_EX1_DR : TAP_SH_DR;
      TAP_EX1_DR: state_d = tms ? TAP_UPD_DR : TAP_PAU_DR;
      TAP_PAU_DR: state_d = tms ? TAP_EX2_DR : TAP_PAU_DR;
      TAP_EX2_DR: state_d = tms ? TAP_UPD_DR : TAP_SH_DR;
      TAP_UPD_DR: state_d = tms ? TAP_SEL_DR : TAP_IDLE;
      TAP_SEL_IR: state_d = tms ? TAP_RESET  : TAP_CAP_IR;
      TAP_CAP_IR: state_d = tms ? TAP_EX1_IR : TAP_SH_IR;
      TAP_SH_IR:  state_d = tms ? TAP_EX1_IR : TAP_SH_IR;
      TAP_EX1_IR: state_d = tms ? TAP_UPD_IR : TAP_PAU_IR;
      TAP_PAU_IR: state_d = tms ? TAP_EX2_IR : TAP_PAU_IR;
      TAP_EX2_IR: state_d = tms ? TAP_UPD_IR : TAP_SH_IR;
      TAP_UPD_IR: state_d = tms ? TAP_SEL_DR : TAP_IDLE;
      default:    state_d = TAP_RESET;
    endcase
  end

  always_comb begin
    case (ir_q)
      IR_IDCODE: idcode_sel = 1'b1;
      IR_BYPASS: idcode_sel = 1'b0;
      default:   idcode_sel = 1'b0;
    endcase
  end

  // State, instruction and TDO
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= TAP_RESET;
      ir_q    <= IR_IDCODE;
      tdo_q   <= 1'b0;
    end else if (!trst_sync_q[1]) begin
      state_q <= TAP_RESET;
      ir_q    <= IR_IDCODE;
      tdo_q   <= 1'b0;
    end else begin
      if (tck_rise) begin
        state_q <= state_d;
        if (state_q == TAP_RESET) begin
          ir_q <= IR_IDCODE;
        end else if (state_q == TAP_UPD_IR) begin
          ir_q <= ir_sr_q;
        end
      end
      if (tck_fall) begin
        unique case (state_q)
          TAP_SH_DR: tdo_q <= idcode_sel ? dr_sr_q[0] : bypass_q;
          TAP_SH_IR: tdo_q <= ir_sr_q[0];
          default:   tdo_q <= 1'b0;
        endcase
      end
    end
  end

  // Shift registers, LSB first
  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      unique case (state_q)
        TAP_CAP_IR: ir_sr_q <= 4'b0101;
        TAP_SH_IR:  ir_sr_q <= {tdi, ir_sr_q[3:1]};
        TAP_CAP_DR: begin
          dr_sr_q  <= JTAG_IDCODE;
          bypass_q <= 1'b0;
        end
        TAP_SH_DR: begin
          dr_sr_q  <= {tdi, dr_sr_q[31:1]};
          bypass_q <= tdi;
        end
        default: ;
      endcase
    end
  end

  assign tdo_o = tdo_q;

endmodule

// ==== hw/mbox_ram.sv ====
//**************************************************************************
// 16-word mailbox with combinational read. Every write returns one credit
// in the next cycle. Status and log writes pulse their valid for one cycle.
//**************************************************************************
`timescale 1ns/1ps

module mbox_ram import chip_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       wr_valid_i,
  input  mbox_addr_t wr_addr_i,
  input  word_t      wr_data_i,
  input  mbox_addr_t rd_addr_i,
  output word_t      rd_data_o,
  output logic       credit_o,
  output logic       status_valid_o,
  output word_t      status_o,
  output logic       log_valid_o,
  output word_t      log_o
);

  word_t mem_q [16];
  logic  credit_q;
  logic  status_valid_q;
  logic  log_valid_q;

  // Mailbox words read as zero until written
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 16; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_valid_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Credit return and snoop pulses
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q       <= 1'b0;
      status_valid_q <= 1'b0;
      log_valid_q    <= 1'b0;
    end else begin
      credit_q       <= wr_valid_i;
      status_valid_q <= wr_valid_i && (wr_addr_i == MBOX_STATUS_ADDR);
      log_valid_q    <= wr_valid_i && (wr_addr_i == MBOX_LOG_ADDR);
    end
  end

  assign rd_data_o = mem_q[rd_addr_i];
  assign credit_o  = credit_q;

  // The word is already stored when its pulse is high
  assign status_valid_o = status_valid_q;
  assign status_o       = mem_q[MBOX_STATUS_ADDR];
  assign log_valid_o    = log_valid_q;
  assign log_o          = mem_q[MBOX_LOG_ADDR];

endmodule

// ==== hw/spi_mbox_dev.sv ====
//**************************************************************************
// SPI mode 0 mailbox device, oversampled by clk. SCK must stay below clk/8.
// Frame is 8 command bits then 32 data bits, MSB first. Only one write can
// wait for a credit; a further write frame before it retires is not held.
//**************************************************************************
`timescale 1ns/1ps

module spi_mbox_dev import chip_pkg::*; #(
  parameter int MBOX_CREDITS = 2
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       csb_i,
  input  logic       credit_i,
  input  word_t      rd_data_i,
  output logic       sdo_o,
  output logic       wr_valid_o,
  output mbox_addr_t wr_addr_o,
  output word_t      wr_data_o,
  output mbox_addr_t rd_addr_o
);

  localparam int CNT_W = $clog2(MBOX_CREDITS + 1);

  logic [1:0]       sck_sync_q;
  logic [1:0]       sdi_sync_q;
  logic [1:0]       csb_sync_q;
  logic             sck_prev_q;
  logic             sck_rise;
  logic             sck_fall;
  logic             sdi;
  logic             csb;
  spi_state_e       state_q;
  logic [5:0]       bit_cnt_q;
  frame_cmd_t       cmd_q;
  word_t            rx_q;
  word_t            tx_q;
  logic             frame_done;
  logic             pend_q;
  mbox_addr_t       pend_addr_q;
  word_t            pend_data_q;
  logic [CNT_W-1:0] credit_cnt_q;
  logic             issue;

  // Two-flop synchronizers; sdi takes the same path to stay aligned with sck
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_sync_q <= 2'b00;
      sdi_sync_q <= 2'b00;
      csb_sync_q <= 2'b11;
      sck_prev_q <= 1'b0;
    end else begin
      sck_sync_q <= {sck_sync_q[0], sck_i};
      sdi_sync_q <= {sdi_sync_q[0], sdi_i};
      csb_sync_q <= {csb_sync_q[0], csb_i};
      sck_prev_q <= sck_sync_q[1];
    end
  end

  assign sdi      = sdi_sync_q[1];
  assign csb      = csb_sync_q[1];
  assign sck_rise = sck_sync_q[1] & ~sck_prev_q;
  assign sck_fall = ~sck_sync_q[1] & sck_prev_q;

  // bit_cnt_q counts rising edges over the whole 40-bit frame
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= SPI_IDLE;
      bit_cnt_q <= '0;
      cmd_q     <= '0;
    end else if (csb) begin
      state_q   <= SPI_IDLE;
      bit_cnt_q <= '0;
    end else begin
      unique case (state_q)
        SPI_IDLE: state_q <= SPI_CMD;
        SPI_CMD: begin
          if (sck_rise) begin
            cmd_q     <= {cmd_q[6:0], sdi};
            bit_cnt_q <= bit_cnt_q + 6'd1;
            if (bit_cnt_q == 6'd7) begin
              state_q <= SPI_DATA;
            end
          end
        end
        SPI_DATA: begin
          if (sck_rise) begin
            if (bit_cnt_q == 6'd39) begin
              // Back-to-back frames reuse the open csb
              bit_cnt_q <= '0;
              state_q   <= SPI_CMD;
            end else begin
              bit_cnt_q <= bit_cnt_q + 6'd1;
            end
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  assign frame_done = !csb && sck_rise && (state_q == SPI_DATA) && (bit_cnt_q == 6'd39);

  always_ff @(posedge clk_i) begin
    if (sck_rise && (state_q == SPI_DATA)) begin
      rx_q <= {rx_q[30:0], sdi};
    end
  end

  // Read data is loaded on the first falling edge of the data phase
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_q <= '0;
    end else if (csb) begin
      tx_q <= '0;
    end else if (sck_fall && (state_q == SPI_DATA)) begin
      if ((bit_cnt_q == 6'd8) && !cmd_q[7]) begin
        tx_q <= rd_data_i;
      end else begin
        tx_q <= {tx_q[30:0], 1'b0};
      end
    end
  end

  assign sdo_o     = tx_q[31];
  assign rd_addr_o = cmd_q[3:0];

  // Write queue and credit counter
  assign issue = pend_q && (credit_cnt_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q       <= 1'b0;
      credit_cnt_q <= CNT_W'(MBOX_CREDITS);
    end else begin
      if (issue) begin
        pend_q <= 1'b0;
      end
      if (frame_done && cmd_q[7]) begin
        pend_q <= 1'b1;
      end
      case ({issue, credit_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_done && cmd_q[7]) begin
      pend_addr_q <= cmd_q[3:0];
      pend_data_q <= {rx_q[30:0], sdi};
    end
  end

  assign wr_valid_o = issue;
  assign wr_addr_o  = pend_addr_q;
  assign wr_data_o  = pend_data_q;

endmodule

// ==== verif/chip_dps_asserts.sv ====
//**************************************************************************
// Checks on the mailbox credits, the strap latch and pad sharing.
// Bound into chip_dps_top; the credit count is taken from inside u_spi_dev.
//**************************************************************************
`timescale 1ns/1ps

module chip_dps_asserts #(
  parameter int MBOX_CREDITS = 2
) (
  input logic                               clk_i,
  input logic                               arst_n_i,
  input logic [$clog2(MBOX_CREDITS + 1)-1:0] credit_cnt_i,
  input logic                               wr_valid_i,
  input logic                               credit_ret_i,
  input logic                               strap_taken_i,
  input logic                               strap_i,
  input logic                               spi_csb_i,
  input logic                               spi_sck_i,
  input logic                               jtag_tck_i,
  input logic                               jtag_trst_n_i
);

  int fail_count = 0;
  int outstanding_q;

  // Writes sent to the mailbox whose credit has not come back yet
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 0;
    end else if (wr_valid_i && !credit_ret_i) begin
      outstanding_q <= outstanding_q + 1;
    end else if (!wr_valid_i && credit_ret_i) begin
      outstanding_q <= outstanding_q - 1;
    end
  end

  credit_range_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_cnt_i <= MBOX_CREDITS)
  else begin
    fail_count++;
    $error("Credit count %0d exceeds %0d", credit_cnt_i, MBOX_CREDITS);
  end

  // A write may only leave the device while a credit is held
  write_credit_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_valid_i |-> (outstanding_q < MBOX_CREDITS))
  else begin
    fail_count++;
    $error("Mailbox write issued with no credit");
  end

  strap_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    strap_taken_i |=> (strap_taken_i && $stable(strap_i)))
  else begin
    fail_count++;
    $error("Latched strap changed without a reset");
  end

  // SPI active and JTAG active never at the same time
  pad_exclusive_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !((!spi_csb_i || spi_sck_i) && (jtag_tck_i || jtag_trst_n_i)))
  else begin
    fail_count++;
    $error("SPI and JTAG ports both see live pads");
  end

endmodule

bind chip_dps_top chip_dps_asserts #(
  .MBOX_CREDITS (MBOX_CREDITS)
) u_asserts (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .credit_cnt_i  (u_spi_dev.credit_cnt_q),
  .wr_valid_i    (wr_valid),
  .credit_ret_i  (credit),
  .strap_taken_i (u_pad_mux.strap_taken_q),
  .strap_i       (u_pad_mux.strap_q),
  .spi_csb_i     (spi_csb),
  .spi_sck_i     (spi_sck),
  .jtag_tck_i    (jtag_tck),
  .jtag_trst_n_i (jtag_trst_n)
);

// ==== verif/tb_chip_dps.sv ====
//**************************************************************************
// Directed testbench for the debug-pad subsystem. SCK and TCK run at clk/12.
// Expected mailbox contents come from a local record of the SPI writes.
//**************************************************************************
`timescale 1ns/1ps

module tb_chip_dps import chip_pkg::*; ();

  localparam int          HALF_PERIOD  = 6;
  localparam logic [15:0] LFSR_SEED    = 16'd25;
  localparam int          MBOX_CREDITS = 2;
  localparam int          NUM_FRAMES   = 70;
  localparam int          JTAG_CLOCKS  = 176;
  localparam longint      WATCHDOG_NS  = (NUM_FRAMES * 40 * 12 + JTAG_CLOCKS * 12) * 40 * 2;

  logic  clk = 1'b0;
  logic  arst_n;
  logic  sck_tck;
  logic  sdi_tdi;
  logic  csb_tms;
  logic  trst_n;
  logic  strap;
  logic  sdo_tdo;
  logic  status_valid;
  word_t status;
  logic  log_valid;
  word_t log_word;

  word_t       exp_mem [16];
  word_t       status_seen [$];
  word_t       log_seen [$];
  logic [15:0] lfsr_q = LFSR_SEED;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          assert_fails;

  chip_dps_top #(
    .MBOX_CREDITS (MBOX_CREDITS)
  ) u_chip_dps_top (
    .clk_i                  (clk),
    .arst_n_i               (arst_n),
    .dps_sck_tck_i          (sck_tck),
    .dps_sdi_tdi_i          (sdi_tdi),
    .dps_csb_tms_i          (csb_tms),
    .dps_trst_n_i           (trst_n),
    .dps_strap_jtag_spi_n_i (strap),
    .dps_sdo_tdo_o          (sdo_tdo),
    .status_valid_o         (status_valid),
    .status_o               (status),
    .log_valid_o            (log_valid),
    .log_o                  (log_word)
  );

  always #20 clk = ~clk;

  // Snoop monitor
  always @(posedge clk) begin
    if (status_valid) begin
      status_seen.push_back(status);
    end
    if (log_valid) begin
      log_seen.push_back(log_word);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      w = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic int pulse_count(input bit use_log);
    return use_log ? log_seen.size() : status_seen.size();
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic apply_reset(input logic jtag_mode);
    @(posedge clk);
    arst_n  <= 1'b0;
    strap   <= jtag_mode;
    sck_tck <= 1'b0;
    sdi_tdi <= 1'b0;
    csb_tms <= 1'b1;
    trst_n  <= 1'b1;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int i = 0; i < 16; i++) begin
      exp_mem[i] = '0;
    end
    status_seen.delete();
    log_seen.delete();
  endtask

  task automatic wait_pulses(input bit use_log, input int count, input int max_cycles);
    int n;
    n = 0;
    while (pulse_count(use_log) < count && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (pulse_count(use_log) < count) begin
      errors++;
      $display("Error at %0d ns: expected %0d %s pulses within %0d cycles, only %0d came",
               $time, count, use_log ? "log" : "status", max_cycles, pulse_count(use_log));
    end
  endtask

  // Host side of one 40-bit frame, sdo sampled just before each rising SCK
  task automatic spi_frame(input frame_cmd_t cmd, input word_t wdata, input bit hold_csb,
                           output word_t rdata);
    logic [39:0] frame;
    frame = {cmd, wdata};
    rdata = '0;
    if (csb_tms) begin
      @(posedge clk);
      csb_tms <= 1'b0;
      repeat (HALF_PERIOD - 1) @(posedge clk);
    end
    for (int i = 39; i >= 0; i--) begin
      @(posedge clk);
      sck_tck <= 1'b0;
      sdi_tdi <= frame[i];
      repeat (HALF_PERIOD - 1) @(posedge clk);
      @(negedge clk);
      if (i < 32) begin
        rdata[i] = sdo_tdo;
      end
      @(posedge clk);
      sck_tck <= 1'b1;
      repeat (HALF_PERIOD - 1) @(posedge clk);
    end
    @(posedge clk);
    sck_tck <= 1'b0;
    repeat (HALF_PERIOD - 1) @(posedge clk);
    if (!hold_csb) begin
      @(posedge clk);
      csb_tms <= 1'b1;
      repeat (HALF_PERIOD - 1) @(posedge clk);
    end
  endtask

  task automatic spi_write(input mbox_addr_t addr, input word_t data, input bit hold_csb);
    word_t unused;
    // Bits 6..4 are don't-care, so send a non-zero pattern there
    spi_frame({1'b1, 3'b101, addr}, data, hold_csb, unused);
    exp_mem[addr] = data;
  endtask

  task automatic spi_read(input mbox_addr_t addr, output word_t data);
    spi_frame({1'b0, 3'b010, addr}, '0, 1'b0, data);
  endtask

  // One TCK period, TDO sampled just before the rising edge
  task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
    @(posedge clk);
    sck_tck <= 1'b0;
    csb_tms <= tms;
    sdi_tdi <= tdi;
    repeat (HALF_PERIOD - 1) @(posedge clk);
    @(negedge clk);
    tdo = sdo_tdo;
    @(posedge clk);
    sck_tck <= 1'b1;
    repeat (HALF_PERIOD - 1) @(posedge clk);
  endtask

  task automatic jtag_reset();
    logic tdo;
    for (int i = 0; i < 5; i++) begin
      jtag_clock(1'b1, 1'b0, tdo);
    end
    jtag_clock(1'b0, 1'b0, tdo);
  endtask

  // From Run-Test/Idle back to Run-Test/Idle
  task automatic jtag_shift_ir(input logic [3:0] ir);
    logic tdo;
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    for (int i = 0; i < 4; i++) begin
      jtag_clock(i == 3, ir[i], tdo);
    end
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
  endtask

  task automatic jtag_shift_dr(input word_t din, output word_t dout);
    logic tdo;
    dout = '0;
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    for (int i = 0; i < 32; i++) begin
      jtag_clock(i == 31, din[i], tdo);
      dout[i] = tdo;
    end
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
  endtask

  task automatic spi_readback(input string name);
    int    err0;
    word_t rdata;
    err0 = errors;
    for (int a = 0; a < 14; a++) begin
      spi_write(mbox_addr_t'(a), rand_word(), 1'b0);
    end
    // Words 14 and 15 stay unwritten here
    for (int a = 0; a < 16; a++) begin
      spi_read(mbox_addr_t'(a), rdata);
      check_value($sformatf("dps_sdo_tdo_o read of mailbox[%0d]", a), rdata, exp_mem[a]);
    end
    finish_test(name, err0);
  endtask

  task automatic status_snoop();
    int    err0;
    word_t value;
    err0 = errors;
    value = rand_word();
    spi_write(MBOX_STATUS_ADDR, value, 1'b0);
    wait_pulses(1'b0, 1, 50);
    repeat (20) @(posedge clk);
    check_value("status_valid_o pulse count", status_seen.size(), 1);
    if (status_seen.size() > 0) begin
      check_value("status_o", status_seen[0], value);
    end
    status_seen.delete();
    log_seen.delete();
    spi_write(4'd9, rand_word(), 1'b0);
    repeat (20) @(posedge clk);
    check_value("status_valid_o pulses after other write", status_seen.size(), 0);
    check_value("log_valid_o pulses after other write", log_seen.size(), 0);
    finish_test("Status snoop", err0);
  endtask

  task automatic log_burst();
    int    err0;
    word_t values [5];
    err0 = errors;
    log_seen.delete();
    for (int i = 0; i < 5; i++) begin
      values[i] = rand_word();
      spi_write(MBOX_LOG_ADDR, values[i], i < 4);
    end
    wait_pulses(1'b1, 5, 100);
    repeat (20) @(posedge clk);
    check_value("log_valid_o pulse count", log_seen.size(), 5);
    for (int i = 0; i < 5 && i < log_seen.size(); i++) begin
      check_value($sformatf("log_o of write %0d", i), log_seen[i], values[i]);
    end
    finish_test("Log snoop, back-to-back frames", err0);
  endtask

  task automatic idcode_readout();
    int    err0;
    word_t dout;
    err0 = errors;
    apply_reset(1'b1);
    jtag_reset();
    jtag_shift_dr('0, dout);
    check_value("IDCODE on dps_sdo_tdo_o", dout, JTAG_IDCODE);
    finish_test("JTAG IDCODE", err0);
  endtask

  task automatic bypass_delay();
    int    err0;
    word_t din;
    word_t dout;
    err0 = errors;
    jtag_shift_ir(IR_BYPASS);
    din = rand_word();
    jtag_shift_dr(din, dout);
    check_value("BYPASS output on dps_sdo_tdo_o", dout, {din[30:0], 1'b0});
    finish_test("JTAG BYPASS", err0);
  endtask

  task automatic strap_latching();
    int    err0;
    word_t rdata;
    word_t dout;
    err0 = errors;
    status_seen.delete();
    log_seen.delete();
    // Chip is still strapped for JTAG, SPI traffic must go nowhere
    spi_frame({1'b1, 3'b000, MBOX_STATUS_ADDR}, rand_word(), 1'b0, rdata);
    spi_frame({1'b0, 3'b000, MBOX_STATUS_ADDR}, '0, 1'b0, rdata);
    check_value("dps_sdo_tdo_o in SPI read while in JTAG mode", rdata, '0);
    jtag_reset();
    jtag_shift_dr('0, dout);
    check_value("IDCODE in JTAG mode", dout, JTAG_IDCODE);
    @(posedge clk);
    strap <= 1'b0;
    repeat (4) @(posedge clk);
    spi_frame({1'b1, 3'b000, MBOX_LOG_ADDR}, rand_word(), 1'b0, rdata);
    jtag_reset();
    jtag_shift_dr('0, dout);
    check_value("IDCODE after strap pad toggle", dout, JTAG_IDCODE);
    repeat (20) @(posedge clk);
    check_value("status_valid_o pulses in JTAG mode", status_seen.size(), 0);
    check_value("log_valid_o pulses in JTAG mode", log_seen.size(), 0);
    finish_test("Strap latching", err0);
    apply_reset(1'b0);
  endtask

  initial begin
    arst_n  = 1'b0;
    sck_tck = 1'b0;
    sdi_tdi = 1'b0;
    csb_tms = 1'b1;
    trst_n  = 1'b1;
    strap   = 1'b0;
    apply_reset(1'b0);
    spi_readback("SPI write and read-back");
    status_snoop();
    log_burst();
    idcode_readout();
    bypass_delay();
    strap_latching();
    spi_readback("SPI read-back after new strap");
    assert_fails = u_chip_dps_top.u_asserts.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             tests, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
